//--- src/soc_bus_pkg.sv
package soc_bus_pkg;

	// Both host ports and the slave bus carry one full register word per access.
	localparam int bus_data_w = 32;	// Width of every register word on the bus.
	localparam int bus_addr_w = 4;	// Word address width, so sixteen slots exist.

	// Word addresses of the mapped registers.
	// Address 0 belongs to the display and 1 to 5 to the timer block.
	localparam logic [bus_addr_w-1:0] reg_seg_digits  = 4'd0;	// Eight hex digits.
	localparam logic [bus_addr_w-1:0] reg_timer_ctrl  = 4'd1;	// Timer control word.
	localparam logic [bus_addr_w-1:0] reg_timer_load  = 4'd2;	// Timer reload value.
	localparam logic [bus_addr_w-1:0] reg_timer_count = 4'd3;	// Live count, read only.
	localparam logic [bus_addr_w-1:0] reg_int_pending = 4'd4;	// Write ones to clear.
	localparam logic [bus_addr_w-1:0] reg_int_mask    = 4'd5;	// Ones let a source through.

	// Anything from 6 upward is unmapped and reads as zero.

endpackage

//--- src/soc_periph_pkg.sv
package soc_periph_pkg;

	// The timer control register is stored and read back as a whole word.
	// The timer logic only looks at the low two bits.
	typedef union packed {
		logic [31:0] raw;	// Word as written by the host.
		struct packed {
			logic [29:0] reserved;	// Kept so software reads back what it wrote.
			logic        auto_reload;	// Reload from the load register on expiry.
			logic        enable;	// Count while set.
		} fields;
	} timer_ctrl_u;

	// Interrupt pending and mask bit numbering.
	localparam int int_timer    = 0;	// Timer expiry.
	localparam int int_ext_base = 1;	// External interrupt 0, the others follow it.
	localparam int ext_int_num  = 3;	// Number of external interrupt inputs.

endpackage

//--- src/signal_holder.sv
module signal_holder #(
	parameter int HOLD = 1000	// Number of cycles the output outlasts the input.
) (
	input  logic clk,
	input  logic hold_in,
	output logic hold_out
);

	// One spare state keeps the width legal when HOLD is zero.
	localparam int cnt_w = (HOLD > 0) ? $clog2(HOLD + 1) : 1;

	logic [cnt_w-1:0] cnt;	// Cycles left before the output may drop.

	// The counter is kept full while the input is asserted and runs out afterwards.
	always_ff @(posedge clk) begin
		if (hold_in) begin
			cnt <= cnt_w'(HOLD);	// Restart the hold window.
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;	// Count the hold window down.
		end
	end

	// High with the input and then for HOLD more cycles.
	assign hold_out = hold_in | (cnt != '0);	// Input passes through with no delay.

endmodule

//--- src/bus_arbiter.sv
module bus_arbiter import soc_bus_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  sys_active,
	input  logic                  h0_stb,
	input  logic                  h0_we,
	input  logic [bus_addr_w-1:0] h0_addr,
	input  logic [bus_data_w-1:0] h0_wdata,
	output logic                  h0_ack,
	output logic [bus_data_w-1:0] h0_rdata,
	input  logic                  h1_stb,
	input  logic                  h1_we,
	input  logic [bus_addr_w-1:0] h1_addr,
	input  logic [bus_data_w-1:0] h1_wdata,
	output logic                  h1_ack,
	output logic [bus_data_w-1:0] h1_rdata,
	output logic                  bus_stb,
	output logic                  bus_we,
	output logic [bus_addr_w-1:0] bus_addr,
	output logic [bus_data_w-1:0] bus_wdata,
	output logic                  bus_sel_seg,
	output logic                  bus_sel_tmr,
	input  logic [bus_data_w-1:0] bus_rdata_seg,
	input  logic [bus_data_w-1:0] bus_rdata_tmr
);

	localparam logic [1:0] st_idle   = 2'd0;	// Waiting for a request.
	localparam logic [1:0] st_access = 2'd1;	// Slave bus strobe is out.
	localparam logic [1:0] st_ack    = 2'd2;	// Ack pulse goes to the winner.

	logic [1:0]            state;	// Access phase.
	logic                  gnt;	// Port that owns the current access.
	logic                  last_gnt;	// Port served last, loses the next tie.
	logic                  pick;	// Port that wins if a grant happens now.
	logic [bus_addr_w-1:0] pick_addr;	// Address of the winning request.
	logic [bus_data_w-1:0] rdata_mux;	// Read data from the selected slave.

	// A port asking alone always wins. On a tie the port not served last wins.
	assign pick      = (h0_stb && h1_stb) ? ~last_gnt : h1_stb;
	assign pick_addr = pick ? h1_addr : h0_addr;

	// Unmapped addresses select no slave and read back zero.
	assign rdata_mux = bus_sel_seg ? bus_rdata_seg :
	                   bus_sel_tmr ? bus_rdata_tmr : '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= st_idle;
			gnt      <= 1'b0;
			last_gnt <= 1'b1;	// Port 0 gets the first tie.
			bus_stb  <= 1'b0;
			h0_ack   <= 1'b0;
			h1_ack   <= 1'b0;
		end else begin
			bus_stb <= 1'b0;	// Strobe and acks are single pulses.
			h0_ack  <= 1'b0;
			h1_ack  <= 1'b0;
			case (state)
				st_idle: begin
					if (sys_active && (h0_stb || h1_stb)) begin	// Requests wait for enable.
						state    <= st_access;
						gnt      <= pick;
						last_gnt <= pick;
						bus_stb  <= 1'b1;
					end
				end
				st_access: begin
					state  <= st_ack;	// Slave answered during the strobe cycle.
					h0_ack <= ~gnt;
					h1_ack <= gnt;
				end
				default: state <= st_idle;	// The held request is not sampled again here.
			endcase
		end
	end

	// Request fields are copied while idle and only count together with bus_stb.
	always_ff @(posedge clk) begin
		if (state == st_idle) begin
			bus_we      <= pick ? h1_we : h0_we;
			bus_addr    <= pick_addr;
			bus_wdata   <= pick ? h1_wdata : h0_wdata;
			bus_sel_seg <= (pick_addr == reg_seg_digits);
			bus_sel_tmr <= (pick_addr >= reg_timer_ctrl) && (pick_addr <= reg_int_mask);
		end
		if (state == st_access) begin	// Read data lines up with the ack.
			if (gnt) begin
				h1_rdata <= rdata_mux;
			end else begin
				h0_rdata <= rdata_mux;
			end
		end
	end

endmodule

//--- src/seg_display.sv
module seg_display import soc_bus_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  bus_stb,
	input  logic                  bus_sel_seg,
	input  logic                  bus_we,
	input  logic [bus_data_w-1:0] bus_wdata,
	output logic [bus_data_w-1:0] bus_rdata_seg,
	output logic [55:0]           seg
);

	logic [bus_data_w-1:0] digits;	// One nibble per display digit, digit 0 lowest.
	logic                  blank;	// Display dark until software writes it.

	// Hex digit to segments, active low, segment a in bit 0 and g in bit 6.
	function automatic logic [6:0] hex_to_seg(input logic [3:0] hex);
		case (hex)
			4'h0: return 7'h40;
			4'h1: return 7'h79;
			4'h2: return 7'h24;
			4'h3: return 7'h30;
			4'h4: return 7'h19;
			4'h5: return 7'h12;
			4'h6: return 7'h02;
			4'h7: return 7'h78;
			4'h8: return 7'h00;
			4'h9: return 7'h10;
			4'ha: return 7'h08;
			4'hb: return 7'h03;	// Lower case b, so it differs from 8.
			4'hc: return 7'h46;
			4'hd: return 7'h21;	// Lower case d, so it differs from 0.
			4'he: return 7'h06;
			default: return 7'h0e;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			blank <= 1'b1;	// All segments off after reset.
		end else if (bus_stb && bus_sel_seg && bus_we) begin
			blank <= 1'b0;	// The first write lights the display.
		end
	end

	always_ff @(posedge clk) begin
		if (bus_stb && bus_sel_seg && bus_we) begin
			digits <= bus_wdata;
		end
	end

	assign bus_rdata_seg = blank ? '0 : digits;	// Digits are undefined until written.

	// Digit i drives segment bits 7*i up to 7*i+6.
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			seg[i*7 +: 7] = blank ? 7'h7f : hex_to_seg(digits[i*4 +: 4]);
		end
	end

endmodule

//--- src/timer_intc.sv
module timer_intc import soc_bus_pkg::*; import soc_periph_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   sys_active,
	input  logic                   bus_stb,
	input  logic                   bus_sel_tmr,
	input  logic                   bus_we,
	input  logic [bus_addr_w-1:0]  bus_addr,
	input  logic [bus_data_w-1:0]  bus_wdata,
	output logic [bus_data_w-1:0]  bus_rdata_tmr,
	input  logic [ext_int_num-1:0] ext_int,
	output logic                   irq
);

	localparam int int_w = ext_int_num + 1;	// Timer plus the external sources.

	timer_ctrl_u            ctrl;	// Enable and reload mode.
	logic [bus_data_w-1:0]  load;	// Reload value.
	logic [bus_data_w-1:0]  count;	// Live count.
	logic [int_w-1:0]       pending;	// Latched interrupt sources.
	logic [int_w-1:0]       mask;	// Sources allowed onto irq.
	logic [ext_int_num-1:0] ext_s1;	// First synchronizer stage.
	logic [ext_int_num-1:0] ext_s2;	// Second synchronizer stage.
	logic [ext_int_num-1:0] ext_s3;	// Previous synced value for edge detect.
	logic                   wr;	// Write strobe for this block.
	logic                   tmr_hit;	// Count reaches zero this cycle.
	logic [int_w-1:0]       int_set;	// Sources that fire this cycle.

	assign wr      = bus_stb && bus_sel_tmr && bus_we;
	assign tmr_hit = sys_active && ctrl.fields.enable && (count == 1);

	always_comb begin
		int_set            = '0;
		int_set[int_timer] = tmr_hit;
		int_set[int_ext_base +: ext_int_num] = ext_s2 & ~ext_s3;	// Rising edges only.
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ctrl.raw <= '0;	// Timer stopped.
			count    <= '0;
			pending  <= '0;
			mask     <= '0;	// Every source masked.
			ext_s1   <= '0;
			ext_s2   <= '0;
			ext_s3   <= '0;
			irq      <= 1'b0;
		end else begin
			ext_s1 <= ext_int;
			ext_s2 <= ext_s1;
			ext_s3 <= ext_s2;
			if (wr && bus_addr == reg_timer_ctrl) begin
				ctrl.raw <= bus_wdata;
			end
			if (wr && bus_addr == reg_timer_load) begin
				count <= bus_wdata;	// A new load value also restarts the count.
			end else if (tmr_hit) begin
				count <= ctrl.fields.auto_reload ? load : '0;	// Zero leaves it stopped.
			end else if (sys_active && ctrl.fields.enable && count != '0) begin
				count <= count - 1'b1;
			end
			if (wr && bus_addr == reg_int_mask) begin
				mask <= bus_wdata[int_w-1:0];
			end
			// A new event in the same cycle as a clear is kept.
			if (wr && bus_addr == reg_int_pending) begin
				pending <= (pending & ~bus_wdata[int_w-1:0]) | int_set;
			end else begin
				pending <= pending | int_set;
			end
			irq <= |(pending & mask);
		end
	end

	always_ff @(posedge clk) begin
		if (wr && bus_addr == reg_timer_load) begin
			load <= bus_wdata;
		end
	end

	always_comb begin
		case (bus_addr)
			reg_timer_ctrl:  bus_rdata_tmr = ctrl.raw;	// Reserved bits read back as written.
			reg_timer_load:  bus_rdata_tmr = load;
			reg_timer_count: bus_rdata_tmr = count;
			reg_int_pending: bus_rdata_tmr = bus_data_w'(pending);
			reg_int_mask:    bus_rdata_tmr = bus_data_w'(mask);
			default:         bus_rdata_tmr = '0;
		endcase
	end

endmodule

//--- src/soc_ip_top.sv
module soc_ip_top import soc_bus_pkg::*; import soc_periph_pkg::*; #(
	parameter int RST_HOLD = 1000,	// Cycles the reset lasts after the key.
	parameter int EN_HOLD  = 100	// Further cycles until the system runs.
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   h0_stb,
	input  logic                   h0_we,
	input  logic [bus_addr_w-1:0]  h0_addr,
	input  logic [bus_data_w-1:0]  h0_wdata,
	output logic                   h0_ack,
	output logic [bus_data_w-1:0]  h0_rdata,
	input  logic                   h1_stb,
	input  logic                   h1_we,
	input  logic [bus_addr_w-1:0]  h1_addr,
	input  logic [bus_data_w-1:0]  h1_wdata,
	output logic                   h1_ack,
	output logic [bus_data_w-1:0]  h1_rdata,
	input  logic [ext_int_num-1:0] ext_int,
	output logic [55:0]            seg,
	output logic                   irq,
	output logic                   sys_active
);

	logic                  rst_hold;	// Stretched reset.
	logic                  en_hold;	// High until the system may run.
	logic                  blk_rst_n;	// Reset seen by the blocks.
	logic                  bus_stb;
	logic                  bus_we;
	logic [bus_addr_w-1:0] bus_addr;
	logic [bus_data_w-1:0] bus_wdata;
	logic                  bus_sel_seg;
	logic                  bus_sel_tmr;
	logic [bus_data_w-1:0] bus_rdata_seg;
	logic [bus_data_w-1:0] bus_rdata_tmr;

	assign blk_rst_n  = rst_n & ~rst_hold;
	assign sys_active = ~en_hold;	// The enable follows the reset.

	signal_holder #(.HOLD(RST_HOLD)) hold_reset (
		.clk      (clk),
		.hold_in  (~rst_n),
		.hold_out (rst_hold)
	);

	signal_holder #(.HOLD(EN_HOLD)) hold_en (
		.clk      (clk),
		.hold_in  (rst_hold),
		.hold_out (en_hold)
	);

	bus_arbiter arbiter (
		.clk, .sys_active, .rst_n (blk_rst_n),
		.h0_stb, .h0_we, .h0_addr, .h0_wdata, .h0_ack, .h0_rdata,
		.h1_stb, .h1_we, .h1_addr, .h1_wdata, .h1_ack, .h1_rdata,
		.bus_stb, .bus_we, .bus_addr, .bus_wdata, .bus_sel_seg, .bus_sel_tmr,
		.bus_rdata_seg, .bus_rdata_tmr
	);

	seg_display display (
		.clk, .rst_n (blk_rst_n),
		.bus_stb, .bus_sel_seg, .bus_we, .bus_wdata, .bus_rdata_seg, .seg
	);

	timer_intc timer (
		.clk, .rst_n (blk_rst_n), .sys_active,
		.bus_stb, .bus_sel_tmr, .bus_we, .bus_addr, .bus_wdata, .bus_rdata_tmr,
		.ext_int, .irq
	);

endmodule

//--- verification/soc_assert.sv
module soc_assert (
	input logic clk,
	input logic rst_n,
	input logic sys_active,
	input logic h0_ack,
	input logic h1_ack
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;	// Failed assertions, summed into the testbench result.

	// Only one access is in flight, so only one port can be answered.
	one_ack: assert property (@(posedge clk) disable iff (!rst_n) !(h0_ack && h1_ack))
		else begin
			$error("Both host ports were acknowledged in the same cycle.");
			fail_count++;
		end

	h0_pulse: assert property (@(posedge clk) disable iff (!rst_n) h0_ack |=> !h0_ack)
		else begin
			$error("Port 0 ack lasted more than one cycle.");
			fail_count++;
		end

	h1_pulse: assert property (@(posedge clk) disable iff (!rst_n) h1_ack |=> !h1_ack)
		else begin
			$error("Port 1 ack lasted more than one cycle.");
			fail_count++;
		end

	// Requests made before the enable must wait for it.
	idle_no_ack: assert property (@(posedge clk) disable iff (!rst_n)
		!sys_active |-> !(h0_ack || h1_ack))
		else begin
			$error("An ack was given while sys_active was low.");
			fail_count++;
		end

endmodule

bind bus_arbiter soc_assert ack_checks (
	.clk, .rst_n, .sys_active, .h0_ack, .h1_ack
);

//--- verification/soc_tb.sv
module soc_tb import soc_bus_pkg::*, soc_periph_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int rst_hold_cycles = 4;	// Short holds keep the startup quick.
	localparam int en_hold_cycles  = 6;	// Enable follows the reset hold by this much.
	localparam int ack_timeout     = 40;	// Cycles a port waits for its ack.
	localparam int timer_load      = 6;	// Start value in the timer interrupt test.
	localparam int burst_len       = 4;	// Write and read pairs per port under contention.

	logic                   clk;
	logic                   rst_n;
	logic                   h0_stb;
	logic                   h0_we;
	logic [bus_addr_w-1:0]  h0_addr;
	logic [bus_data_w-1:0]  h0_wdata;
	logic                   h0_ack;
	logic [bus_data_w-1:0]  h0_rdata;
	logic                   h1_stb;
	logic                   h1_we;
	logic [bus_addr_w-1:0]  h1_addr;
	logic [bus_data_w-1:0]  h1_wdata;
	logic                   h1_ack;
	logic [bus_data_w-1:0]  h1_rdata;
	logic [ext_int_num-1:0] ext_int;
	logic [55:0]            seg;
	logic                   irq;
	logic                   sys_active;

	integer seed;	// Drives the idle gaps between accesses.
	int     errors;	// Every failed check and timeout.
	int     checks;	// Number of checks made.
	int     timeouts;	// Waits that ran out.
	int     test_err;	// Error count when the current test began.
	bit     record_order;	// Ack order is logged while set.
	int     ack_order[$];	// Ports in the order their acks came.

	soc_ip_top #(
		.RST_HOLD (rst_hold_cycles),
		.EN_HOLD  (en_hold_cycles)
	) DUT (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;	// 40 ns period.
	end

	// Segment letters lit for each hex digit, turned into active-low bits with a in bit 0.
	function automatic logic [6:0] seg_pattern(input logic [3:0] hex);
		string      lit;
		logic [6:0] pat;
		int         pos;
		case (hex)
			4'h0: lit = "abcdef";
			4'h1: lit = "bc";
			4'h2: lit = "abdeg";
			4'h3: lit = "abcdg";
			4'h4: lit = "bcfg";
			4'h5: lit = "acdfg";
			4'h6: lit = "acdefg";
			4'h7: lit = "abc";
			4'h8: lit = "abcdefg";
			4'h9: lit = "abcdfg";
			4'ha: lit = "abcefg";
			4'hb: lit = "cdefg";	// Lower case b.
			4'hc: lit = "adef";
			4'hd: lit = "bcdeg";	// Lower case d.
			4'he: lit = "adefg";
			default: lit = "aefg";
		endcase
		pat = 7'h7f;	// All segments dark.
		for (int i = 0; i < lit.len(); i++) begin
			pos = int'(lit[i]) - 97;	// Letter a maps to bit 0.
			pat[pos] = 1'b0;
		end
		return pat;
	endfunction

	task automatic check_word(input string what, input logic [bus_data_w-1:0] got,
		input logic [bus_data_w-1:0] exp);
		checks++;
		if (got !== exp) begin
			$display("ERR %0t: %s returned %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_display(input logic [bus_data_w-1:0] word);
		for (int d = 0; d < 8; d++) begin
			checks++;
			if (seg[d*7 +: 7] !== seg_pattern(word[d*4 +: 4])) begin
				$display("ERR %0t: digit %0d shows %h for nibble %h, expected %h", $time, d,
					seg[d*7 +: 7], word[d*4 +: 4], seg_pattern(word[d*4 +: 4]));
				errors++;
			end
		end
	endtask

	// Starts on a falling edge, holds the request until the ack and drops the strobe.
	task automatic bus_access(input int port, input logic we, input logic [bus_addr_w-1:0] addr,
		input logic [bus_data_w-1:0] wdata, output logic [bus_data_w-1:0] rdata);
		int   waited;
		logic got;
		waited = 0;
		got    = 1'b0;
		rdata  = '0;
		if (port == 0) begin
			h0_we    = we;
			h0_addr  = addr;
			h0_wdata = wdata;
			h0_stb   = 1'b1;
		end else begin
			h1_we    = we;
			h1_addr  = addr;
			h1_wdata = wdata;
			h1_stb   = 1'b1;
		end
		while (!got && waited < ack_timeout) begin
			@(negedge clk);
			waited++;
			got = (port == 0) ? h0_ack : h1_ack;	// Ack is stable between edges.
		end
		if (got) begin
			rdata = (port == 0) ? h0_rdata : h1_rdata;	// Registered with the ack.
			if (record_order) begin
				ack_order.push_back(port);
			end
		end else begin
			$display("Timeout: port %0d got no acknowledge for address %0h", port, addr);
			errors++;
			timeouts++;
		end
		if (port == 0) begin
			h0_stb = 1'b0;
		end else begin
			h1_stb = 1'b0;
		end
	endtask

	task automatic wait_irq(input logic level, input int limit, input string what);
		int waited;
		waited = 0;
		while (irq !== level && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		checks++;
		if (irq !== level) begin
			$display("Timeout: irq did not reach %b within %0d cycles in %s", level, limit, what);
			errors++;
			timeouts++;
		end
	endtask

	task automatic idle_gap();
		repeat ({$random(seed)} % 4) @(negedge clk);	// Zero to three idle cycles.
	endtask

	// Back to back accesses, each port on a register that the other one leaves alone.
	task automatic port_burst(input int port);
		logic [bus_data_w-1:0] val;
		logic [bus_data_w-1:0] rd;
		logic [bus_addr_w-1:0] addr;
		addr = (port == 0) ? reg_timer_load : reg_seg_digits;
		for (int i = 0; i < burst_len; i++) begin
			val = ((port == 0) ? 32'h5a5a_0100 : 32'h0fed_cba0) + 32'(i);
			bus_access(port, 1'b1, addr, val, rd);
			bus_access(port, 1'b0, addr, '0, rd);
			check_word($sformatf("port %0d burst read %0d", port, i), rd, val);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: failed with %0d errors", name, errors - errs_before);
		end
	endtask

	initial begin
		logic [bus_data_w-1:0] rd;
		logic [bus_data_w-1:0] va;
		logic [bus_data_w-1:0] vd;
		logic [bus_data_w-1:0] ve;
		logic [bus_data_w-1:0] bit_val;
		int                    vm;
		int                    vw;
		int                    fd;
		int                    got;
		int                    nvec;
		int                    cycles;
		int                    polls;
		string                 line;

		seed         = 32'h36fa4d0b;
		errors       = 0;
		checks       = 0;
		timeouts     = 0;
		record_order = 1'b0;
		rst_n        = 1'b0;	// Reset key pressed from the start.
		h0_stb       = 1'b0;
		h0_we        = 1'b0;
		h0_addr      = '0;
		h0_wdata     = '0;
		h1_stb       = 1'b0;
		h1_we        = 1'b0;
		h1_addr      = '0;
		h1_wdata     = '0;
		ext_int      = '0;

		test_err = errors;
		repeat (3) @(negedge clk);
		rst_n   = 1'b1;
		h0_addr = reg_int_mask;	// Early read that has to wait for the enable.
		h0_stb  = 1'b1;
		cycles  = 0;
		while (!sys_active && cycles < rst_hold_cycles + en_hold_cycles + 8) begin
			@(negedge clk);
			cycles++;
			checks++;
			if (!sys_active && (seg !== '1 || irq !== 1'b0 || h0_ack !== 1'b0)) begin
				$display("ERR %0t: before enable seg %h irq %b ack %b", $time, seg, irq, h0_ack);
				errors++;
			end
		end
		if (!sys_active) begin
			$display("Timeout: sys_active did not rise within %0d cycles", cycles);
			errors++;
			timeouts++;
		end else if (cycles < rst_hold_cycles + en_hold_cycles) begin
			$display("ERR %0t: sys_active rose after only %0d cycles", $time, cycles);
			errors++;
		end
		bus_access(0, 1'b0, reg_int_mask, '0, rd);	// Collects the held early request.
		check_word("early mask read", rd, '0);
		report_test("startup", test_err);

		test_err = errors;
		nvec     = 0;
		fd       = $fopen("verification/soc_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open verification/soc_vectors.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				got = $fgets(line, fd);	// Comment lines fail the scan and are skipped.
				if (got != 0 && $sscanf(line, "%d %d %h %h %h", vm, vw, va, vd, ve) == 5) begin
					nvec++;
					idle_gap();
					bus_access(vm, vw != 0, va[bus_addr_w-1:0], vd, rd);
					if (vw == 0) begin
						check_word($sformatf("vector %0d read of %0h", nvec, va), rd, ve);
					end else if (va[bus_addr_w-1:0] == reg_seg_digits) begin
						check_display(vd);	// Segments already follow the write at the ack.
					end
				end
			end
			$fclose(fd);
		end
		if (nvec == 0) begin
			$display("No access vectors were read from the vector file");
			errors++;
		end
		report_test("register access", test_err);

		test_err = errors;
		bus_access(1, 1'b1, reg_seg_digits, 32'h0123_4567, rd);
		check_display(32'h0123_4567);
		bus_access(0, 1'b1, reg_seg_digits, 32'h89ab_cdef, rd);
		check_display(32'h89ab_cdef);
		bus_access(1, 1'b0, reg_seg_digits, '0, rd);
		check_word("digit read back", rd, 32'h89ab_cdef);
		report_test("display", test_err);

		test_err = errors;
		ack_order.delete();
		record_order = 1'b1;
		@(negedge clk);	// Both ports raise their strobes on the same edge.
		fork
			port_burst(0);
			port_burst(1);
		join
		record_order = 1'b0;
		checks++;
		if (ack_order.size() != 4 * burst_len) begin
			$display("ERR %0t: %0d acks seen, expected %0d", $time, ack_order.size(), 4 * burst_len);
			errors++;
		end
		for (int j = 1; j < ack_order.size(); j++) begin
			if (ack_order[j] == ack_order[j-1]) begin
				$display("ERR %0t: port %0d won twice in a row at ack %0d", $time, ack_order[j], j);
				errors++;
			end
		end
		report_test("arbitration", test_err);

		test_err = errors;
		bit_val = 32'(1) << int_timer;
		bus_access(0, 1'b1, reg_int_mask, bit_val, rd);
		bus_access(1, 1'b1, reg_timer_load, timer_load, rd);	// Also restarts the count.
		bus_access(0, 1'b1, reg_timer_ctrl, 32'h1, rd);	// Enable, one shot.
		wait_irq(1'b1, timer_load + 8, "timer expiry");
		bus_access(1, 1'b0, reg_int_pending, '0, rd);
		check_word("pending after expiry", rd, bit_val);
		bus_access(0, 1'b0, reg_timer_count, '0, rd);
		check_word("count after one shot", rd, '0);
		bus_access(1, 1'b1, reg_int_pending, bit_val, rd);	// Write one to clear.
		wait_irq(1'b0, 8, "timer clear");
		bus_access(0, 1'b1, reg_timer_ctrl, '0, rd);
		report_test("timer interrupt", test_err);

		test_err = errors;
		for (int k = 0; k < ext_int_num; k++) begin
			bit_val = 32'(1) << (int_ext_base + k);
			idle_gap();
			bus_access(k % 2, 1'b1, reg_int_mask, '0, rd);	// Everything masked.
			ext_int[k] = 1'b1;
			repeat (2) @(negedge clk);
			ext_int[k] = 1'b0;
			polls = 0;
			rd    = '0;
			while ((rd & bit_val) == '0 && polls < 10) begin
				bus_access(k % 2, 1'b0, reg_int_pending, '0, rd);
				polls++;
			end
			check_word($sformatf("pending after pulse on input %0d", k), rd, bit_val);
			checks++;
			if (irq !== 1'b0) begin
				$display("ERR %0t: irq is %b with input %0d masked", $time, irq, k);
				errors++;
			end
			bus_access((k + 1) % 2, 1'b1, reg_int_mask, bit_val, rd);
			wait_irq(1'b1, 8, $sformatf("unmask of input %0d", k));
			bus_access(k % 2, 1'b1, reg_int_pending, bit_val, rd);
			wait_irq(1'b0, 8, $sformatf("clear of input %0d", k));
		end
		report_test("external interrupts", test_err);

		if (DUT.arbiter.ack_checks.fail_count != 0) begin
			$display("Bus handshake assertions failed %0d times", DUT.arbiter.ack_checks.fail_count);
			errors += DUT.arbiter.ack_checks.fail_count;
		end
		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- verification/soc_vectors.txt
# Columns: port, write flag, word address, write data, expected read data (last three in hex).
# A write ignores the expected column and a read ignores the data column.
0 1 0 0000c0de 00000000
1 0 0 00000000 0000c0de
1 1 1 a5a5fffc 00000000
0 0 1 00000000 a5a5fffc
0 1 2 00001234 00000000
1 0 2 00000000 00001234
0 0 3 00000000 00001234
1 1 5 0000000a 00000000
0 0 5 00000000 0000000a
1 0 4 00000000 00000000
0 1 7 deadbeef 00000000
1 0 7 00000000 00000000
0 0 6 00000000 00000000
1 0 f 00000000 00000000
1 1 5 00000000 00000000
0 0 5 00000000 00000000
1 1 1 00000000 00000000
0 0 1 00000000 00000000

//--- flist.f
src/soc_bus_pkg.sv
src/soc_periph_pkg.sv
src/signal_holder.sv
src/bus_arbiter.sv
src/seg_display.sv
src/timer_intc.sv
src/soc_ip_top.sv
verification/soc_assert.sv
verification/soc_tb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and searches the log for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f flist.f --top-module soc_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vsoc_tb +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if grep -q "^Simulation completed successfully$" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
